// File: list.f
verilog/lsu_pkg.sv
verilog/oram_bank.sv
verilog/lsu_instr_ctrl.sv
verilog/mxu_row_store.sv
verilog/dram_store.sv
verilog/lsu_top.sv
verif/lsu_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then scan the log for a failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module lsu_tb -f list.f &&
    ./obj_dir/Vlsu_tb > sim.log 2>&1 ||
    { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
exit 0

// File: verif/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    localparam int LIMIT = 2000;

    logic                clk = 1'b0;
    logic                reset;
    logic                instr_vld;
    lsu_instr_t          instr;
    logic                instr_rdy;
    mxu_rows_t           mxu_rows;
    logic                mxu_data_rdy = 1'b0;
    axi_aw_t             aw;
    logic                awvld;
    logic                awrdy = 1'b0;
    logic [BEAT_W-1:0]   wdata;
    logic                wvld;
    logic                wlast;
    logic                wrdy = 1'b0;
    logic [1:0]          bresp;
    logic                bvld = 1'b0;
    logic                brdy;
    logic                st_err;

    int                  seed;
    int                  errors;
    int                  err_at_start;
    int                  tests_run;
    int                  tests_failed;
    string               test_name;
    logic                bp;
    logic [ROW_W-1:0]    shadow [256];
    logic [BEAT_W-1:0]   exp_beats [$];
    lsu_instr_t          dram_ins;
    int                  beats_seen;
    int                  aw_seen;
    int                  aw_wait = 0;
    int                  b_wait = 0;

    lsu_top #(
        .ORAM_DEPTH (256)
    ) dut_i (
        .clk          (clk),
        .reset        (reset),
        .instr_vld    (instr_vld),
        .instr        (instr),
        .instr_rdy    (instr_rdy),
        .mxu_rows     (mxu_rows),
        .mxu_data_rdy (mxu_data_rdy),
        .aw           (aw),
        .awvld        (awvld),
        .awrdy        (awrdy),
        .wdata        (wdata),
        .wvld         (wvld),
        .wlast        (wlast),
        .wrdy         (wrdy),
        .bresp        (bresp),
        .bvld         (bvld),
        .brdy         (brdy),
        .st_err       (st_err)
    );

    always #5 clk = ~clk;

    // handshake rules on the write channels
    a_aw_hold: assert property (@(posedge clk) disable iff (reset)
        awvld && !awrdy |=> awvld && $stable(aw))
        else begin
            $display("%s: aw payload or awvld changed before awrdy", test_name);
            errors++;
        end
    a_w_hold: assert property (@(posedge clk) disable iff (reset)
        wvld && !wrdy |=> wvld && $stable(wdata) && $stable(wlast))
        else begin
            $display("%s: write beat changed before wrdy", test_name);
            errors++;
        end
    a_b_hold: assert property (@(posedge clk) disable iff (reset)
        brdy && !bvld |=> brdy)
        else begin
            $display("%s: brdy dropped before bvld", test_name);
            errors++;
        end
    a_wlast: assert property (@(posedge clk) disable iff (reset) wlast |-> wvld)
        else begin
            $display("%s: wlast high without wvld", test_name);
            errors++;
        end

    function automatic logic coin();
        coin = ($random(seed) & 3) != 0;
    endfunction

    function automatic lsu_instr_t make_instr(lsu_op_e op, logic [30:0] daddr, logic [7:0] num,
                                              logic [2:0] len, logic [3:0] sx, logic [3:0] sy,
                                              logic [7:0] word);
        lsu_instr_t ins;
        ins.op        = op;
        ins.dram_addr = daddr;
        ins.num       = num;
        ins.len       = len;
        ins.start_x   = sx;
        ins.start_y   = sy;
        // low nibble is not part of the word address
        ins.sram_addr = {word, 4'h5};
        return ins;
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act)
            else begin
                $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
                errors++;
            end
    endtask

    task automatic note_timeout(input string what);
        $display("%s: timed out waiting for %s", test_name, what);
        errors++;
    endtask

    // ready levels randomized once back-pressure is on
    always @(posedge clk) begin
        // cycles an address or response phase has been stalled
        if (awvld && !awrdy) begin
            aw_wait <= aw_wait + 1;
        end else begin
            aw_wait <= 0;
        end
        if (brdy && !bvld) begin
            b_wait <= b_wait + 1;
        end else begin
            b_wait <= 0;
        end
        if (bp) begin
            mxu_data_rdy <= coin();
            // address and response phases always stall for a few cycles first
            awrdy        <= (aw_wait >= 2) ? coin() : 1'b0;
            wrdy         <= coin();
            bvld         <= (b_wait >= 2) ? coin() : 1'b0;
        end else begin
            mxu_data_rdy <= 1'b1;
            awrdy        <= 1'b1;
            wrdy         <= 1'b1;
            bvld         <= 1'b1;
        end
    end

    // address and beat monitor
    always @(posedge clk) begin
        if (!reset && awvld && awrdy) begin
            aw_seen++;
            check_value("aw.addr", 64'(dram_ins.dram_addr[13:4]), 64'(aw.addr));
            check_value("aw.len", 64'(dram_ins.num), 64'(aw.len));
            check_value("aw.size", 64'(dram_ins.len), 64'(aw.size));
        end
        if (!reset && wvld && wrdy) begin
            assert (exp_beats.size() > 0)
                else begin
                    $display("%s: write beat arrived with none expected", test_name);
                    errors++;
                end
            if (exp_beats.size() > 0) begin
                check_value("wdata", exp_beats.pop_front(), wdata);
                check_value("wlast", 64'(beats_seen == 2 * dram_ins.num - 1), 64'(wlast));
            end
            beats_seen++;
        end
    end

    task automatic wait_ready();
        int t;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!instr_rdy && t < LIMIT);
        if (!instr_rdy) begin
            note_timeout("instr_rdy");
        end
    endtask

    task automatic send_instr(input lsu_instr_t ins);
        int t;
        instr     <= ins;
        instr_vld <= 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!instr_rdy && t < LIMIT);
        instr_vld <= 1'b0;
        if (!instr_rdy) begin
            note_timeout("instruction accept");
        end
    endtask

    task automatic store_rows(input logic [7:0] word, input logic [3:0] sy, input logic [7:0] num,
                              input logic [2:0] len, input logic [3:0] sx);
        mxu_rows_t  rows;
        lsu_instr_t ins;
        int         lo;
        int         wid;
        lo  = sx;
        wid = 1 << len;
        for (int r = 0; r < MXU_ROWS; r++) begin
            for (int w = 0; w < ROW_W / 32; w++) begin
                rows[r][w*32 +: 32] = $random(seed);
            end
        end
        ins = make_instr(OP_ST_ORAM, 31'h0, num, len, sx, sy, word);
        // shadow keeps bytes outside the window
        for (int k = 0; k < num; k++) begin
            for (int b = lo; b < ROW_BYTES && b < lo + wid; b++) begin
                shadow[8'(word + k)][b*8 +: 8] = rows[4'(sy + k)][b*8 +: 8];
            end
        end
        wait_ready();
        mxu_rows <= rows;
        send_instr(ins);
    endtask

    task automatic store_dram(input logic [30:0] daddr, input logic [7:0] word,
                              input logic [7:0] num, input logic [1:0] resp);
        lsu_instr_t ins;
        int         t;
        ins = make_instr(OP_ST_DRAM, daddr, num, 3'd3, 4'd0, 4'd0, word);
        for (int k = 0; k < num; k++) begin
            exp_beats.push_back(shadow[8'(word + k)][63:0]);
            exp_beats.push_back(shadow[8'(word + k)][127:64]);
        end
        wait_ready();
        dram_ins   = ins;
        beats_seen = 0;
        aw_seen    = 0;
        bresp     <= resp;
        send_instr(ins);
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!(brdy && bvld) && t < LIMIT);
        if (!(brdy && bvld)) begin
            note_timeout("write response");
        end
        @(posedge clk);
        check_value("st_err", 64'(resp != 2'b00), 64'(st_err));
        check_value("beat count", 64'(2 * num), 64'(beats_seen));
        check_value("address phases", 64'd1, 64'(aw_seen));
        check_value("beats left", 64'd0, 64'(exp_beats.size()));
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        err_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors > err_at_start) begin
            tests_failed++;
        end
        $display("test %s finished with %0d error(s)", test_name, errors - err_at_start);
    endtask

    initial begin
        seed      = 32'h2f5e_d302;
        bp        <= 1'b0;
        reset     <= 1'b1;
        instr_vld <= 1'b0;
        instr     <= '0;
        mxu_rows  <= '0;
        bresp     <= 2'b00;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        start_test("reset");
        check_value("instr_rdy", 64'd1, 64'(instr_rdy));
        check_value("awvld", 64'd0, 64'(awvld));
        check_value("wvld", 64'd0, 64'(wvld));
        check_value("brdy", 64'd0, 64'(brdy));
        check_value("st_err", 64'd0, 64'(st_err));
        end_test();

        start_test("full_rows");
        store_rows(8'd8, 4'd2, 8'd6, 3'd4, 4'd0);
        store_dram(31'h0004_5670, 8'd8, 8'd6, 2'b00);
        end_test();

        // narrow windows laid over full words and clipped at byte 15
        start_test("narrow");
        store_rows(8'd20, 4'd0, 8'd4, 3'd4, 4'd0);
        store_rows(8'd20, 4'd5, 8'd4, 3'd1, 4'd3);
        store_rows(8'd21, 4'd9, 8'd2, 3'd0, 4'd15);
        store_rows(8'd22, 4'd1, 8'd2, 3'd3, 4'd12);
        store_rows(8'd20, 4'd14, 8'd3, 3'd2, 4'd6);
        store_dram(31'h0000_1230, 8'd20, 8'd4, 2'b00);
        end_test();

        start_test("aw_phase");
        bp <= 1'b1;
        store_dram(31'h7abc_def0, 8'd8, 8'd3, 2'b00);
        end_test();

        start_test("backpressure");
        store_rows(8'd40, 4'd0, 8'd10, 3'd4, 4'd0);
        store_rows(8'd43, 4'd7, 8'd5, 3'd2, 4'd9);
        store_dram(31'h0010_0400, 8'd40, 8'd10, 2'b00);
        end_test();

        start_test("resp_err");
        store_dram(31'h0000_0100, 8'd40, 8'd2, 2'b10);
        repeat (3) @(posedge clk);
        check_value("st_err held", 64'd1, 64'(st_err));
        store_rows(8'd60, 4'd3, 8'd2, 3'd4, 4'd0);
        @(posedge clk);
        check_value("st_err cleared", 64'd0, 64'(st_err));
        wait_ready();
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/dram_store.sv
`timescale 1ns/1ps

module dram_store (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  lsu_pkg::lsu_instr_t        cur,
    output lsu_pkg::axi_aw_t           aw,
    output logic                       awvld,
    input  logic                       awrdy,
    output lsu_pkg::sram_req_t         rd_req,
    input  logic [lsu_pkg::ROW_W-1:0]  rd_data,
    output logic [lsu_pkg::BEAT_W-1:0] wdata,
    output logic                       wvld,
    output logic                       wlast,
    input  logic                       wrdy,
    input  logic                       bvld,
    output logic                       brdy,
    output logic                       done
);
    import lsu_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,
        S_READ,
        S_LOW,
        S_HIGH,
        S_RESP
    } state_e;

    state_e             state;
    logic [7:0]         row_cnt;
    logic [8:0]         beat_cnt;
    logic [8:0]         last_beat;
    logic               rd_vld;
    logic [ROW_W-1:0]   row_buf;
    logic [ROW_W-1:0]   row_data;
    logic [SRAM_AW-1:0] rd_addr;

    // address payload comes straight from the latched instruction
    assign aw.addr = cur.dram_addr[13:4];
    assign aw.len  = cur.num;
    assign aw.size = cur.len;
    assign awvld   = (state == S_ADDR);

    assign rd_addr = cur.sram_addr[11:4] + row_cnt;

    always_comb begin
        rd_req.ce      = (state == S_READ);
        rd_req.we      = 1'b0;
        rd_req.addr    = rd_addr;
        rd_req.byte_en = '0;
        rd_req.wdata   = '0;
    end

    // first low beat uses the fresh read, later cycles the buffer
    assign row_data  = rd_vld ? rd_data : row_buf;
    assign wdata     = (state == S_HIGH) ? row_data[ROW_W-1:BEAT_W] : row_data[BEAT_W-1:0];
    assign wvld      = (state == S_LOW) || (state == S_HIGH);
    assign last_beat = {cur.num, 1'b0} - 9'd1;
    assign wlast     = wvld && (beat_cnt == last_beat);

    assign brdy = (state == S_RESP);
    assign done = brdy & bvld;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_IDLE;
            row_cnt  <= '0;
            beat_cnt <= '0;
            rd_vld   <= 1'b0;
        end else begin
            rd_vld <= rd_req.ce;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state    <= S_ADDR;
                        row_cnt  <= '0;
                        beat_cnt <= '0;
                    end
                end
                S_ADDR: begin
                    if (awrdy) begin
                        state <= S_READ;
                    end
                end
                S_READ: state <= S_LOW;
                S_LOW: begin
                    if (wrdy) begin
                        state    <= S_HIGH;
                        beat_cnt <= beat_cnt + 9'd1;
                    end
                end
                S_HIGH: begin
                    if (wrdy) begin
                        beat_cnt <= beat_cnt + 9'd1;
                        row_cnt  <= row_cnt + 8'd1;
                        state    <= wlast ? S_RESP : S_READ;
                    end
                end
                S_RESP: begin
                    if (bvld) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // hold the row while the high beat waits for wrdy
    always_ff @(posedge clk) begin
        if (rd_vld) begin
            row_buf <= rd_data;
        end
    end

endmodule

// File: verilog/lsu_instr_ctrl.sv
`timescale 1ns/1ps

module lsu_instr_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                instr_vld,
    input  lsu_pkg::lsu_instr_t instr,
    output logic                instr_rdy,
    output lsu_pkg::lsu_instr_t cur,
    output logic                start_row,
    output logic                start_dram,
    input  logic                row_done,
    input  logic                dram_done,
    input  logic                bvld,
    input  logic [1:0]          bresp,
    input  logic                brdy,
    output logic                st_err
);
    import lsu_pkg::*;

    logic busy;
    logic finish;
    logic accept;
    logic resp_err;

    assign finish    = row_done | dram_done;
    // a new instruction may enter in the finish cycle
    assign instr_rdy = ~busy | finish;
    assign accept    = instr_vld & instr_rdy;
    assign resp_err  = bvld & brdy & (|bresp);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            start_row  <= 1'b0;
            start_dram <= 1'b0;
            st_err     <= 1'b0;
        end else begin
            if (accept) begin
                busy <= 1'b1;
            end else if (finish) begin
                busy <= 1'b0;
            end
            start_row  <= accept && (instr.op == OP_ST_ORAM);
            start_dram <= accept && (instr.op == OP_ST_DRAM);
            // an error in the accept cycle belongs to the finishing store, keep it
            if (resp_err) begin
                st_err <= 1'b1;
            end else if (accept) begin
                st_err <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur <= instr;
        end
    end

endmodule

// File: verilog/lsu_pkg.sv
package lsu_pkg;

    // row and word geometry
    localparam int ROW_BYTES = 16;
    localparam int ROW_W     = ROW_BYTES * 8;
    localparam int BEAT_W    = 64;
    localparam int SRAM_AW   = 8;
    localparam int MXU_ROWS  = 16;

    // instruction opcodes kept by this unit
    typedef enum logic {
        OP_ST_ORAM = 1'b0,
        OP_ST_DRAM = 1'b1
    } lsu_op_e;

    // decoder payload, latched once per instruction
    typedef struct packed {
        lsu_op_e     op;
        logic [30:0] dram_addr;
        logic [7:0]  num;
        logic [2:0]  len;
        logic [3:0]  start_x;
        logic [3:0]  start_y;
        logic [11:0] sram_addr;
    } lsu_instr_t;

    // one oram access
    typedef struct packed {
        logic                 ce;
        logic                 we;
        logic [SRAM_AW-1:0]   addr;
        logic [ROW_BYTES-1:0] byte_en;
        logic [ROW_W-1:0]     wdata;
    } sram_req_t;

    // write address channel payload
    typedef struct packed {
        logic [9:0] addr;
        logic [7:0] len;
        logic [2:0] size;
    } axi_aw_t;

    // int8 result rows of the matrix unit
    typedef logic [MXU_ROWS-1:0][ROW_W-1:0] mxu_rows_t;

endpackage

// File: verilog/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
    parameter int ORAM_DEPTH = 256
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       instr_vld,
    input  lsu_pkg::lsu_instr_t        instr,
    output logic                       instr_rdy,
    input  lsu_pkg::mxu_rows_t         mxu_rows,
    input  logic                       mxu_data_rdy,
    output lsu_pkg::axi_aw_t           aw,
    output logic                       awvld,
    input  logic                       awrdy,
    output logic [lsu_pkg::BEAT_W-1:0] wdata,
    output logic                       wvld,
    output logic                       wlast,
    input  logic                       wrdy,
    input  logic [1:0]                 bresp,
    input  logic                       bvld,
    output logic                       brdy,
    output logic                       st_err
);
    import lsu_pkg::*;

    lsu_instr_t       cur;
    logic             start_row;
    logic             start_dram;
    logic             row_done;
    logic             dram_done;
    sram_req_t        row_req;
    sram_req_t        rd_req;
    logic [ROW_W-1:0] rd_data;

    lsu_instr_ctrl ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .instr_vld  (instr_vld),
        .instr      (instr),
        .instr_rdy  (instr_rdy),
        .cur        (cur),
        .start_row  (start_row),
        .start_dram (start_dram),
        .row_done   (row_done),
        .dram_done  (dram_done),
        .bvld       (bvld),
        .bresp      (bresp),
        .brdy       (brdy),
        .st_err     (st_err)
    );

    mxu_row_store row_i (
        .clk          (clk),
        .reset        (reset),
        .start        (start_row),
        .cur          (cur),
        .mxu_rows     (mxu_rows),
        .mxu_data_rdy (mxu_data_rdy),
        .row_req      (row_req),
        .done         (row_done)
    );

    dram_store dram_i (
        .clk     (clk),
        .reset   (reset),
        .start   (start_dram),
        .cur     (cur),
        .aw      (aw),
        .awvld   (awvld),
        .awrdy   (awrdy),
        .rd_req  (rd_req),
        .rd_data (rd_data),
        .wdata   (wdata),
        .wvld    (wvld),
        .wlast   (wlast),
        .wrdy    (wrdy),
        .bvld    (bvld),
        .brdy    (brdy),
        .done    (dram_done)
    );

    oram_bank #(
        .DEPTH (ORAM_DEPTH)
    ) oram_i (
        .clk     (clk),
        .row_req (row_req),
        .rd_req  (rd_req),
        .rd_data (rd_data)
    );

endmodule

// File: verilog/mxu_row_store.sv
`timescale 1ns/1ps

module mxu_row_store (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  lsu_pkg::lsu_instr_t cur,
    input  lsu_pkg::mxu_rows_t  mxu_rows,
    input  logic                mxu_data_rdy,
    output lsu_pkg::sram_req_t  row_req,
    output logic                done
);
    import lsu_pkg::*;

    localparam int SEL_W = $clog2(MXU_ROWS);

    logic                 active;
    logic [7:0]           row_cnt;
    logic [SEL_W-1:0]     row_sel;
    logic [SRAM_AW-1:0]   wr_addr;
    logic [ROW_BYTES-1:0] width_mask;
    logic                 wr_fire;
    logic                 last_row;

    // one row per cycle while the matrix data is ready
    assign wr_fire  = active & mxu_data_rdy;
    assign last_row = (row_cnt == cur.num - 8'd1);
    assign done     = wr_fire & last_row;

    // window width is 1 << len bytes
    always_comb begin
        case (cur.len)
            3'd0:    width_mask = 16'h0001;
            3'd1:    width_mask = 16'h0003;
            3'd2:    width_mask = 16'h000f;
            3'd3:    width_mask = 16'h00ff;
            default: width_mask = 16'hffff;
        endcase
    end

    always_comb begin
        row_req.ce      = wr_fire;
        row_req.we      = wr_fire;
        row_req.addr    = wr_addr;
        // bytes outside the window keep their old contents
        row_req.byte_en = width_mask << cur.start_x;
        row_req.wdata   = mxu_rows[row_sel];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active  <= 1'b0;
            row_cnt <= '0;
            row_sel <= '0;
            wr_addr <= '0;
        end else if (start) begin
            active  <= 1'b1;
            row_cnt <= '0;
            row_sel <= cur.start_y;
            wr_addr <= cur.sram_addr[11:4];
        end else if (wr_fire) begin
            row_cnt <= row_cnt + 8'd1;
            row_sel <= row_sel + 1'b1;
            wr_addr <= wr_addr + 1'b1;
            if (last_row) begin
                active <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/oram_bank.sv
`timescale 1ns/1ps

module oram_bank #(
    parameter int DEPTH = 256
) (
    input  logic                      clk,
    input  lsu_pkg::sram_req_t        row_req,
    input  lsu_pkg::sram_req_t        rd_req,
    output logic [lsu_pkg::ROW_W-1:0] rd_data
);
    import lsu_pkg::*;

    logic [ROW_W-1:0] mem [DEPTH];
    sram_req_t        req;

    // matrix row writes win over the dram read port
    assign req = row_req.ce ? row_req : rd_req;

    always_ff @(posedge clk) begin
        if (req.ce && req.we) begin
            for (int b = 0; b < ROW_BYTES; b++) begin
                if (req.byte_en[b]) begin
                    mem[req.addr][b*8 +: 8] <= req.wdata[b*8 +: 8];
                end
            end
        end
        // read data shows up one cycle after ce
        if (req.ce && !req.we) begin
            rd_data <= mem[req.addr];
        end
    end

endmodule
